//--- common/tag_geom_pkg.sv
// ----------------------------------------------------------------------
// Geometry of the tag store. NUM_WAYS must stay a power of two so that
// binary way numbers wrap on their own
// ----------------------------------------------------------------------

package tag_geom_pkg;

  // Associativity and set count
  localparam int unsigned NUM_WAYS = 4;
  localparam int unsigned WAY_BIN_W = 2;
  localparam int unsigned INDEX_W = 4;
  localparam int unsigned NUM_SETS = 2 ** INDEX_W;

  // Stored tag width
  localparam int unsigned TAG_W = 8;

  // Tag plus dirty plus valid
  localparam int unsigned ENTRY_W = TAG_W + 2;

  // ----------------------------------------------------------------------
  // Vector types
  // ----------------------------------------------------------------------

  // One bit per way, used for one-hot selects and lock masks
  typedef logic [NUM_WAYS-1:0] way_ind_t;

  // Binary way number
  typedef logic [WAY_BIN_W-1:0] way_bin_t;

  // Set index, the address into each way
  typedef logic [INDEX_W-1:0] index_t;

  typedef logic [TAG_W-1:0] tag_t;

  // Tag in the low bits, dirty above it, valid on top
  typedef logic [ENTRY_W-1:0] entry_t;

endpackage

//--- common/tag_op_pkg.sv
// ----------------------------------------------------------------------
// Operation encoding and entry field positions. The positions follow
// the entry layout of the geometry package
// ----------------------------------------------------------------------

package tag_op_pkg;

  // ----------------------------------------------------------------------
  // Operations
  // ----------------------------------------------------------------------

  // Lookup compares all unlocked ways and allocates on a miss
  // Flush reads one named way and clears it
  typedef enum logic [0:0] {
    OP_LOOKUP = 1'b0,
    OP_FLUSH  = 1'b1
  } op_mode_e;

  // ----------------------------------------------------------------------
  // Entry layout
  // ----------------------------------------------------------------------

  // Tag occupies bits TAG_W-1 down to 0
  localparam int unsigned ENTRY_TAG_LSB = 0;

  // Dirty sits right above the tag
  localparam int unsigned ENTRY_DIRTY_BIT = tag_geom_pkg::TAG_W;

  // Valid is the top bit of the entry
  localparam int unsigned ENTRY_VALID_BIT = tag_geom_pkg::TAG_W + 1;

  // Consistency of the layout with the entry width
  localparam bit ENTRY_LAYOUT_OK = (ENTRY_VALID_BIT == tag_geom_pkg::ENTRY_W - 1)
                                   && (ENTRY_TAG_LSB == 0);

  // Cleared entry written by a flush
  localparam tag_geom_pkg::entry_t ENTRY_EMPTY = '0;

endpackage

//--- tag_ram/tag_ram.sv
// ----------------------------------------------------------------------
// Entry storage, one bank per way. Read data is registered and held
// until the next read. All entries come out of reset invalid
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tag_ram
  import tag_geom_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  rd_i,
  input  way_ind_t              wr_ways_i,
  input  index_t                index_i,
  input  entry_t                wdata_i,
  output entry_t [NUM_WAYS-1:0] rdata_o
);

  // ----------------------------------------------------------------------
  // Per-way banks
  // ----------------------------------------------------------------------

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way

    entry_t mem_q [NUM_SETS];
    entry_t rdata_q;

    // Writes land on every selected way at the same index
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        for (int s = 0; s < NUM_SETS; s++) begin
          mem_q[s] <= '0;
        end
      end else if (wr_ways_i[w]) begin
        mem_q[index_i] <= wdata_i;
      end
    end

    // One-cycle read latency, output stable while no read is issued
    always_ff @(posedge clk_i) begin
      if (rd_i) begin
        rdata_q <= mem_q[index_i];
      end
    end

    assign rdata_o[w] = rdata_q;

  end

endmodule

//--- tag_lookup/tag_match.sv
// ----------------------------------------------------------------------
// Tag compare and response fields. Purely combinational on the read
// data, so fields stay stable while the read data is held
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tag_match
  import tag_geom_pkg::*;
  import tag_op_pkg::*;
(
  input  op_mode_e              mode_i,
  input  tag_t                  tag_i,
  input  way_ind_t              way_i,
  input  way_ind_t              spm_lock_i,
  input  entry_t [NUM_WAYS-1:0] rdata_i,
  input  way_ind_t              victim_way_i,
  output way_ind_t              hit_way_o,
  output way_ind_t              resp_way_o,
  output logic                  line_dirty_o,
  output logic                  res_hit_o,
  output logic                  res_evict_o,
  output tag_t                  res_evict_tag_o
);

  logic   is_lookup;
  logic   any_hit;
  entry_t sel_entry;
  logic   sel_valid;
  logic   sel_dirty;

  assign is_lookup = (mode_i == OP_LOOKUP);

  // Hit needs a valid, unlocked entry with a matching tag
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_way_o[w] = is_lookup & ~spm_lock_i[w] & rdata_i[w][ENTRY_VALID_BIT]
                     & (rdata_i[w][TAG_W-1:0] == tag_i);
    end
  end

  assign any_hit   = |hit_way_o;
  assign res_hit_o = any_hit;

  // Flush reports its target, lookup the hit or else the victim
  assign resp_way_o = is_lookup ? (any_hit ? hit_way_o : victim_way_i) : way_i;

  // One-hot mux of the reported entry, zero when no way is selected
  always_comb begin
    sel_entry = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (resp_way_o[w]) begin
        sel_entry = sel_entry | rdata_i[w];
      end
    end
  end

  assign sel_valid    = sel_entry[ENTRY_VALID_BIT];
  assign sel_dirty    = sel_entry[ENTRY_DIRTY_BIT];
  assign line_dirty_o = sel_dirty;

  // A hit never evicts
  assign res_evict_o     = ~any_hit & sel_valid & sel_dirty;
  assign res_evict_tag_o = res_evict_o ? sel_entry[TAG_W-1:0] : '0;

endmodule

//--- tag_lookup/evict_select.sv
// ----------------------------------------------------------------------
// Victim choice. Free unlocked ways first, lowest number wins, then
// the round-robin pointer. Zero result when every way is locked
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module evict_select
  import tag_geom_pkg::*;
(
  input  entry_t [NUM_WAYS-1:0] rdata_i,
  input  way_ind_t              spm_lock_i,
  input  way_bin_t              ptr_i,
  output way_ind_t              victim_way_o,
  output logic                  victim_from_ctr_o
);

  way_ind_t free_ways;
  way_ind_t first_free;
  logic     all_locked;

  // Valid is the top entry bit
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      free_ways[w] = ~spm_lock_i[w] & ~rdata_i[w][ENTRY_W-1];
    end
  end

  // Isolate the lowest set bit
  assign first_free = free_ways & way_ind_t'(~free_ways + way_ind_t'(1));
  assign all_locked = &spm_lock_i;

  always_comb begin
    victim_way_o      = '0;
    victim_from_ctr_o = 1'b0;
    if (|free_ways) begin
      victim_way_o = first_free;
    end else if (!all_locked) begin
      // Set is full, the pointer already skips locked ways
      victim_way_o      = way_ind_t'(1) << ptr_i;
      victim_from_ctr_o = 1'b1;
    end
  end

endmodule

//--- hw/victim_counter.sv
// ----------------------------------------------------------------------
// Round-robin victim pointer. The output always names an unlocked way
// unless every way is locked
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module victim_counter
  import tag_geom_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     advance_i,
  input  way_ind_t spm_lock_i,
  output way_bin_t ptr_o
);

  way_bin_t ptr_q;
  way_bin_t ptr_next;

  // Skip forward past locked ways, binary add wraps around the ways
  always_comb begin
    logic     found;
    way_bin_t cand;
    found = 1'b0;
    ptr_o = ptr_q;
    for (int i = 0; i < NUM_WAYS; i++) begin
      cand = way_bin_t'(ptr_q + way_bin_t'(i));
      if (!found && !spm_lock_i[cand]) begin
        ptr_o = cand;
        found = 1'b1;
      end
    end
  end

  // Next unlocked way strictly after the current one
  always_comb begin
    logic     found;
    way_bin_t cand;
    found    = 1'b0;
    ptr_next = ptr_o;
    for (int i = 1; i <= NUM_WAYS; i++) begin
      cand = way_bin_t'(ptr_o + way_bin_t'(i));
      if (!found && !spm_lock_i[cand]) begin
        ptr_next = cand;
        found    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (advance_i) begin
      ptr_q <= ptr_next;
    end
  end

endmodule

//--- hw/tag_ctrl_fsm.sv
// ----------------------------------------------------------------------
// Request sequencing. Read issued on accept, all writes on the response
// handshake, so a read and a write never share a cycle
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tag_ctrl_fsm
  import tag_geom_pkg::*;
  import tag_op_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  op_mode_e req_mode_i,
  input  index_t   req_index_i,
  input  tag_t     req_tag_i,
  input  logic     req_dirty_i,
  input  way_ind_t req_way_i,
  output logic     res_valid_o,
  input  logic     res_ready_i,
  input  way_ind_t hit_way_i,
  input  way_ind_t resp_way_i,
  input  logic     line_dirty_i,
  input  logic     victim_from_ctr_i,
  output op_mode_e mode_o,
  output index_t   index_o,
  output tag_t     tag_o,
  output way_ind_t way_o,
  output logic     ram_rd_o,
  output way_ind_t ram_wr_ways_o,
  output index_t   ram_index_o,
  output entry_t   ram_wdata_o,
  output logic     ctr_advance_o
);

  typedef enum logic {
    ST_IDLE,
    ST_RESPOND
  } state_e;

  state_e   state_q, state_d;
  logic     accept;
  logic     res_done;

  // Captured request
  op_mode_e mode_q;
  index_t   index_q;
  tag_t     tag_q;
  logic     dirty_q;
  way_ind_t way_q;

  // ----------------------------------------------------------------------
  // Handshakes and state
  // ----------------------------------------------------------------------

  assign req_ready_o = (state_q == ST_IDLE);
  assign res_valid_o = (state_q == ST_RESPOND);
  assign accept      = req_valid_i & req_ready_o;
  assign res_done    = res_valid_o & res_ready_i;

  always_comb begin
    state_d = state_q;
    if (accept) begin
      state_d = ST_RESPOND;
    end else if (res_done) begin
      state_d = ST_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request payload, held for the whole response phase
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mode_q  <= req_mode_i;
      index_q <= req_index_i;
      tag_q   <= req_tag_i;
      dirty_q <= req_dirty_i;
      way_q   <= req_way_i;
    end
  end

  assign mode_o  = mode_q;
  assign index_o = index_q;
  assign tag_o   = tag_q;
  assign way_o   = way_q;

  // ----------------------------------------------------------------------
  // Storage access
  // ----------------------------------------------------------------------

  // Read straight from the request while idle
  assign ram_rd_o    = accept;
  assign ram_index_o = req_ready_o ? req_index_i : index_q;

  always_comb begin
    ram_wr_ways_o = '0;
    ram_wdata_o   = ENTRY_EMPTY;
    ctr_advance_o = 1'b0;
    if (res_done) begin
      case (mode_q)
        OP_LOOKUP: begin
          if (|hit_way_i) begin
            // Only a clean line turning dirty needs an update
            if (dirty_q && !line_dirty_i) begin
              ram_wr_ways_o                  = hit_way_i;
              ram_wdata_o[TAG_W-1:0]         = tag_q;
              ram_wdata_o[ENTRY_DIRTY_BIT]   = 1'b1;
              ram_wdata_o[ENTRY_VALID_BIT]   = 1'b1;
            end
          end else if (|resp_way_i) begin
            // Allocate into the victim, nothing when every way is locked
            ram_wr_ways_o                  = resp_way_i;
            ram_wdata_o[TAG_W-1:0]         = tag_q;
            ram_wdata_o[ENTRY_DIRTY_BIT]   = dirty_q;
            ram_wdata_o[ENTRY_VALID_BIT]   = 1'b1;
            // Pointer moves only when it supplied the victim
            ctr_advance_o                  = victim_from_ctr_i;
          end
        end
        OP_FLUSH: begin
          ram_wr_ways_o = way_q;
          ram_wdata_o   = ENTRY_EMPTY;
        end
      endcase
    end
  end

endmodule

//--- hw/tag_store_top.sv
// ----------------------------------------------------------------------
// Tag store top. One request in flight, response one cycle after accept
// spm_lock_i must only change while no request is in flight
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tag_store_top
  import tag_geom_pkg::*;
  import tag_op_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  way_ind_t spm_lock_i,
  // Request side
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  op_mode_e req_mode_i,
  input  index_t   req_index_i,
  input  tag_t     req_tag_i,
  input  logic     req_dirty_i,
  input  way_ind_t req_way_i,
  // Response side
  output logic     res_valid_o,
  input  logic     res_ready_i,
  output way_ind_t res_way_o,
  output logic     res_hit_o,
  output logic     res_evict_o,
  output tag_t     res_evict_tag_o
);

  // Storage control
  logic                  ram_rd;
  way_ind_t              ram_wr_ways;
  index_t                ram_index;
  entry_t                ram_wdata;
  entry_t [NUM_WAYS-1:0] rdata_all;

  // Registered request seen by the match logic
  op_mode_e              cur_mode;
  tag_t                  cur_tag;
  way_ind_t              cur_way;

  // Match and replacement results
  way_ind_t              hit_way;
  way_ind_t              resp_way;
  logic                  line_dirty;
  way_ind_t              victim_way;
  logic                  victim_from_ctr;
  logic                  ctr_advance;
  way_bin_t              ctr_ptr;

  tag_ctrl_fsm u_tag_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .req_mode_i        (req_mode_i),
    .req_index_i       (req_index_i),
    .req_tag_i         (req_tag_i),
    .req_dirty_i       (req_dirty_i),
    .req_way_i         (req_way_i),
    .res_valid_o       (res_valid_o),
    .res_ready_i       (res_ready_i),
    .hit_way_i         (hit_way),
    .resp_way_i        (resp_way),
    .line_dirty_i      (line_dirty),
    .victim_from_ctr_i (victim_from_ctr),
    .mode_o            (cur_mode),
    .index_o           (),
    .tag_o             (cur_tag),
    .way_o             (cur_way),
    .ram_rd_o          (ram_rd),
    .ram_wr_ways_o     (ram_wr_ways),
    .ram_index_o       (ram_index),
    .ram_wdata_o       (ram_wdata),
    .ctr_advance_o     (ctr_advance)
  );

  tag_ram u_tag_ram (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rd_i       (ram_rd),
    .wr_ways_i  (ram_wr_ways),
    .index_i    (ram_index),
    .wdata_i    (ram_wdata),
    .rdata_o    (rdata_all)
  );

  tag_match u_tag_match (
    .mode_i          (cur_mode),
    .tag_i           (cur_tag),
    .way_i           (cur_way),
    .spm_lock_i      (spm_lock_i),
    .rdata_i         (rdata_all),
    .victim_way_i    (victim_way),
    .hit_way_o       (hit_way),
    .resp_way_o      (resp_way),
    .line_dirty_o    (line_dirty),
    .res_hit_o       (res_hit_o),
    .res_evict_o     (res_evict_o),
    .res_evict_tag_o (res_evict_tag_o)
  );

  evict_select u_evict_select (
    .rdata_i           (rdata_all),
    .spm_lock_i        (spm_lock_i),
    .ptr_i             (ctr_ptr),
    .victim_way_o      (victim_way),
    .victim_from_ctr_o (victim_from_ctr)
  );

  victim_counter u_victim_counter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .advance_i  (ctr_advance),
    .spm_lock_i (spm_lock_i),
    .ptr_o      (ctr_ptr)
  );

  // Reported way is the hit, victim or flush target
  assign res_way_o = resp_way;

endmodule

//--- dv/tb_tag_store_ref.svh
// ----------------------------------------------------------------------
// Reference model of the tag store, included inside the testbench body
// Needs the checks and errors counters declared before the include
// ----------------------------------------------------------------------

`ifndef TB_TAG_STORE_REF_SVH
`define TB_TAG_STORE_REF_SVH

// Expected response of one transaction
typedef struct packed {
  way_ind_t way;
  logic     hit;
  logic     evict;
  tag_t     evict_tag;
} exp_res_t;

// Model entries, valid and dirty above the tag
entry_t   model_mem [NUM_SETS][NUM_WAYS];
// Round-robin pointer, one for all sets
way_bin_t model_ptr;

task automatic model_reset();
  for (int s = 0; s < NUM_SETS; s++) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      model_mem[s][w] = '0;
    end
  end
  model_ptr = '0;
endtask

// First unlocked way at start plus skip or later, with wraparound
function automatic way_bin_t unlocked_from(way_bin_t start, int skip, way_ind_t lock);
  way_bin_t cand;
  way_bin_t found;
  logic     done;
  found = start;
  done  = 1'b0;
  for (int i = skip; i < skip + NUM_WAYS; i++) begin
    cand = way_bin_t'((start + i) % NUM_WAYS);
    if (!done && !lock[cand]) begin
      found = cand;
      done  = 1'b1;
    end
  end
  return found;
endfunction

// Unlocked valid entries holding the tag
function automatic way_ind_t ref_hits(index_t idx, tag_t tag, way_ind_t lock);
  way_ind_t hits;
  hits = '0;
  for (int w = 0; w < NUM_WAYS; w++) begin
    hits[w] = !lock[w] && model_mem[idx][w][ENTRY_VALID_BIT]
              && (model_mem[idx][w][TAG_W-1:0] == tag);
  end
  return hits;
endfunction

// Lowest free unlocked way, else the pointer's way, none if all locked
function automatic way_ind_t ref_victim(index_t idx, way_ind_t lock);
  way_ind_t vic;
  vic = '0;
  for (int w = NUM_WAYS - 1; w >= 0; w--) begin
    if (!lock[w] && !model_mem[idx][w][ENTRY_VALID_BIT]) begin
      vic    = '0;
      vic[w] = 1'b1;
    end
  end
  if (vic == '0 && lock != '1) begin
    vic[unlocked_from(model_ptr, 0, lock)] = 1'b1;
  end
  return vic;
endfunction

function automatic exp_res_t ref_result(op_mode_e mode, index_t idx, tag_t tag,
                                        way_ind_t way, way_ind_t lock);
  exp_res_t res;
  way_ind_t hits;
  entry_t   sel;
  res  = '0;
  sel  = '0;
  hits = ref_hits(idx, tag, lock);
  if (mode == OP_FLUSH) begin
    res.way = way;
  end else if (hits != '0) begin
    res.way = hits;
    res.hit = 1'b1;
  end else begin
    res.way = ref_victim(idx, lock);
  end
  // Hits never evict
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (res.way[w] && !res.hit) begin
      sel = model_mem[idx][w];
    end
  end
  res.evict     = sel[ENTRY_VALID_BIT] & sel[ENTRY_DIRTY_BIT];
  res.evict_tag = res.evict ? sel[TAG_W-1:0] : '0;
  return res;
endfunction

// Applies the write rules of one completed transaction
task automatic model_update(op_mode_e mode, index_t idx, tag_t tag, logic dirty,
                            way_ind_t way, way_ind_t lock);
  way_ind_t hits;
  way_ind_t vic;
  hits = ref_hits(idx, tag, lock);
  vic  = ref_victim(idx, lock);
  for (int w = 0; w < NUM_WAYS; w++) begin
    if (mode == OP_FLUSH) begin
      if (way[w]) begin
        model_mem[idx][w] = '0;
      end
    end else if (hits != '0) begin
      if (hits[w] && dirty) begin
        model_mem[idx][w][ENTRY_DIRTY_BIT] = 1'b1;
      end
    end else if (vic[w]) begin
      // Valid victim means the set was full and the pointer chose it
      if (model_mem[idx][w][ENTRY_VALID_BIT]) begin
        model_ptr = unlocked_from(way_bin_t'(w), 1, lock);
      end
      model_mem[idx][w] = {1'b1, dirty, tag};
    end
  end
endtask

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------

task automatic check_way(input string name, input way_ind_t got, input way_ind_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

task automatic check_tag(input string name, input tag_t got, input tag_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
  end
endtask

`endif

//--- dv/tb_tag_store.sv
// ----------------------------------------------------------------------
// Testbench of the tag store. Lock mask changes only between requests
// Responses are checked against the reference model at the handshake
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_tag_store
  import tag_geom_pkg::*;
  import tag_op_pkg::*;
();

  // Transactions over all tests, 20 cycles allowed for each
  localparam int NUM_TXN    = 46;
  localparam int MAX_CYCLES = 20 * NUM_TXN;

  // Request as the compare process sees it
  typedef struct packed {
    op_mode_e mode;
    index_t   idx;
    tag_t     tag;
    logic     dirty;
    way_ind_t way;
  } req_rec_t;

  logic     clk_i = 1'b0;
  logic     rst_n_i;
  way_ind_t spm_lock_i;
  logic     req_valid_i;
  logic     req_ready_o;
  op_mode_e req_mode_i;
  index_t   req_index_i;
  tag_t     req_tag_i;
  logic     req_dirty_i;
  way_ind_t req_way_i;
  logic     res_valid_o;
  logic     res_ready_i;
  way_ind_t res_way_o;
  logic     res_hit_o;
  logic     res_evict_o;
  tag_t     res_evict_tag_o;

  integer   seed = 32'hb7bd_752a;
  int       cycle_cnt = 0;
  int       checks = 0;
  int       errors = 0;
  int       issue_cnt = 0;
  int       done_cnt = 0;
  int       test_cnt = 0;
  int       failed_tests = 0;
  int       test_err0 = 0;
  string    test_name;
  req_rec_t pend_q [$];
  req_rec_t cur_req;

  `include "tb_tag_store_ref.svh"

  exp_res_t cur_exp;

  tag_store_top u_tag_store_top (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .spm_lock_i      (spm_lock_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_mode_i      (req_mode_i),
    .req_index_i     (req_index_i),
    .req_tag_i       (req_tag_i),
    .req_dirty_i     (req_dirty_i),
    .req_way_i       (req_way_i),
    .res_valid_o     (res_valid_o),
    .res_ready_i     (res_ready_i),
    .res_way_o       (res_way_o),
    .res_hit_o       (res_hit_o),
    .res_evict_o     (res_evict_o),
    .res_evict_tag_o (res_evict_tag_o)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run timed out after %0d cycles with responses still pending", cycle_cnt);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Compare process, sampled mid-cycle ahead of the handshake edge
  // ----------------------------------------------------------------------

  always @(negedge clk_i) begin
    if (rst_n_i && res_valid_o && res_ready_i) begin
      if (pend_q.size() == 0) begin
        errors++;
        $display("Response handshake at %0t ns with no request outstanding", $time);
      end else begin
        cur_req = pend_q.pop_front();
        cur_exp = ref_result(cur_req.mode, cur_req.idx, cur_req.tag, cur_req.way, spm_lock_i);
        check_way("res_way_o", res_way_o, cur_exp.way);
        check_bit("res_hit_o", res_hit_o, cur_exp.hit);
        check_bit("res_evict_o", res_evict_o, cur_exp.evict);
        check_tag("res_evict_tag_o", res_evict_tag_o, cur_exp.evict_tag);
        model_update(cur_req.mode, cur_req.idx, cur_req.tag, cur_req.dirty, cur_req.way,
                     spm_lock_i);
        done_cnt++;
      end
    end
  end

  function automatic logic [31:0] draw_random();
    return $random(seed);
  endfunction

  // One request, then stall cycles of back-pressure on the response
  task automatic txn(input op_mode_e mode, input index_t idx, input tag_t tag,
                     input logic dirty, input way_ind_t way, input int stall);
    way_ind_t s_way;
    logic     s_hit;
    logic     s_evict;
    tag_t     s_tag;
    @(posedge clk_i);
    req_valid_i <= 1'b1;
    req_mode_i  <= mode;
    req_index_i <= idx;
    req_tag_i   <= tag;
    req_dirty_i <= dirty;
    req_way_i   <= way;
    res_ready_i <= (stall == 0);
    pend_q.push_back(req_rec_t'{mode, idx, tag, dirty, way});
    issue_cnt++;
    @(negedge clk_i);
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    // Response due one cycle after the accept edge
    @(negedge clk_i);
    check_bit("res_valid_o", res_valid_o, 1'b1);
    while (!res_valid_o) begin
      @(negedge clk_i);
    end
    s_way   = res_way_o;
    s_hit   = res_hit_o;
    s_evict = res_evict_o;
    s_tag   = res_evict_tag_o;
    // Fields frozen and no new request taken across each stalled edge
    for (int n = 0; n < stall; n++) begin
      @(posedge clk_i);
      if (n == stall - 1) begin
        res_ready_i <= 1'b1;
      end
      @(negedge clk_i);
      check_bit("res_valid_o", res_valid_o, 1'b1);
      check_bit("req_ready_o", req_ready_o, 1'b0);
      check_way("res_way_o", res_way_o, s_way);
      check_bit("res_hit_o", res_hit_o, s_hit);
      check_bit("res_evict_o", res_evict_o, s_evict);
      check_tag("res_evict_tag_o", res_evict_tag_o, s_tag);
    end
    @(posedge clk_i);
    res_ready_i <= 1'b0;
    // Idle again in the cycle after the handshake
    @(negedge clk_i);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("res_valid_o", res_valid_o, 1'b0);
  endtask

  task automatic set_lock(input way_ind_t mask);
    @(posedge clk_i);
    spm_lock_i <= mask;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = errors;
    test_cnt++;
  endtask

  task automatic finish_test();
    if (errors == test_err0) begin
      $display("test %0d %s: ok", test_cnt, test_name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", test_cnt, test_name, errors - test_err0);
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  initial begin
    logic [31:0] rnd;
    index_t      set_a;
    index_t      set_b;
    index_t      set_c;
    tag_t        a_tag;
    tag_t        b_tag;
    tag_t        c_tag;
    tag_t        old_tag;
    int          stall;
    rst_n_i     = 1'b0;
    spm_lock_i  = '0;
    req_valid_i = 1'b0;
    req_mode_i  = OP_LOOKUP;
    req_index_i = '0;
    req_tag_i   = '0;
    req_dirty_i = 1'b0;
    req_way_i   = '0;
    res_ready_i = 1'b0;
    model_reset();
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    rnd   = draw_random();
    // Three separate sets, tag bases per set
    set_a = rnd[3:0];
    set_b = set_a + 4'd1;
    set_c = set_a + 4'd2;
    a_tag = rnd[15:8];
    b_tag = rnd[23:16];
    c_tag = rnd[31:24];

    start_test("fill empty set");
    @(negedge clk_i);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    check_bit("res_valid_o", res_valid_o, 1'b0);
    for (int i = 0; i < 4; i++) begin
      txn(OP_LOOKUP, set_a, a_tag + tag_t'(i), 1'b0, '0, 0);
    end
    finish_test();

    start_test("hits and dirty marking");
    for (int i = 0; i < 4; i++) begin
      txn(OP_LOOKUP, set_a, a_tag + tag_t'(i), 1'b0, '0, 0);
    end
    // Clean line goes dirty, then a dirty hit on a dirty line
    txn(OP_LOOKUP, set_a, a_tag + 8'd1, 1'b1, '0, 0);
    txn(OP_LOOKUP, set_a, a_tag + 8'd1, 1'b1, '0, 0);
    finish_test();

    start_test("round-robin replacement");
    rnd = draw_random();
    for (int i = 0; i < 8; i++) begin
      txn(OP_LOOKUP, set_a, a_tag + tag_t'(16 + i), rnd[i], '0, 0);
    end
    finish_test();

    start_test("flush and refill");
    old_tag = model_mem[set_a][2][TAG_W-1:0];
    txn(OP_FLUSH, set_a, '0, 1'b0, 4'b0100, 0);
    txn(OP_LOOKUP, set_a, old_tag, 1'b0, '0, 0);
    old_tag = model_mem[set_a][0][TAG_W-1:0];
    txn(OP_FLUSH, set_a, '0, 1'b0, 4'b0001, 0);
    txn(OP_LOOKUP, set_a, old_tag, 1'b1, '0, 0);
    finish_test();

    start_test("scratchpad locks");
    rnd = draw_random();
    for (int i = 0; i < 4; i++) begin
      txn(OP_LOOKUP, set_b, b_tag + tag_t'(i), rnd[i], '0, 0);
    end
    set_lock(4'b0101);
    txn(OP_LOOKUP, set_b, b_tag + 8'd1, 1'b0, '0, 0);
    // Tag of locked way 0 misses, three misses rotate over ways 1 and 3
    txn(OP_LOOKUP, set_b, b_tag, 1'b0, '0, 0);
    txn(OP_LOOKUP, set_b, b_tag + 8'd4, rnd[4], '0, 0);
    txn(OP_LOOKUP, set_b, b_tag + 8'd5, rnd[5], '0, 0);
    set_lock(4'b1111);
    txn(OP_LOOKUP, set_b, b_tag + 8'd6, 1'b1, '0, 0);
    txn(OP_LOOKUP, set_b, b_tag + 8'd2, 1'b0, '0, 0);
    set_lock(4'b0000);
    txn(OP_LOOKUP, set_b, b_tag + 8'd2, 1'b0, '0, 0);
    txn(OP_LOOKUP, set_b, b_tag, 1'b0, '0, 0);
    finish_test();

    start_test("response back-pressure");
    for (int i = 0; i < 12; i++) begin
      rnd   = draw_random();
      stall = 1 + int'(rnd[7:5]) % 6;
      if (rnd[9:8] == 2'b00) begin
        txn(OP_FLUSH, set_c, '0, 1'b0, 4'b0001 << rnd[1:0], stall);
      end else begin
        txn(OP_LOOKUP, set_c, c_tag + tag_t'(int'(rnd[4:2]) % 5), rnd[10], '0, stall);
      end
    end
    finish_test();

    if (pend_q.size() != 0 || done_cnt != issue_cnt) begin
      errors++;
      $display("Only %0d of %0d responses were seen", done_cnt, issue_cnt);
    end
    $display("Summary: %0d tests, %0d failed tests, %0d transactions, %0d checks, %0d errors",
             test_cnt, failed_tests, done_cnt, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+dv
common/tag_geom_pkg.sv
common/tag_op_pkg.sv
tag_ram/tag_ram.sv
tag_lookup/tag_match.sv
tag_lookup/evict_select.sv
hw/victim_counter.sv
hw/tag_ctrl_fsm.sv
hw/tag_store_top.sv
dv/tb_tag_store.sv
